// File: hw/sdmac_bus_pkg.sv
// SCSI DMA bus definitions
`default_nettype none

package sdmac_bus_pkg;

    // host side word, one 32-bit longword
    localparam int word_w = 32;

    // SCSI side byte
    localparam int byte_w = 8;

    // byte lanes per host word
    localparam int lanes = 4;

    // words held by each word FIFO
    localparam int fifo_depth = 4;

    // byte lanes of a host word, lowest byte first
    // ll is bits 7:0, uu is bits 31:24
    typedef enum logic [1:0] {
        lane_ll = 2'd0,
        lane_lm = 2'd1,
        lane_um = 2'd2,
        lane_uu = 2'd3
    } lane_e;

endpackage

`default_nettype wire

// File: hw/sdmac_ctrl_pkg.sv
// SCSI DMA transfer control definitions
`default_nettype none

package sdmac_ctrl_pkg;

    // width of the transfer byte count
    localparam int count_w = 16;

    // transfer direction as seen from the host
    typedef enum logic {
        dir_to_scsi   = 1'b0,
        dir_from_scsi = 1'b1
    } dir_e;

    // sequencer states
    // idle waits for start, move runs the byte handshakes,
    // flush waits for the last word in the rx direction,
    // done is the one cycle completion pulse
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_move  = 2'd1,
        st_flush = 2'd2,
        st_done  = 2'd3
    } seq_state_e;

endpackage

`default_nettype wire

// File: hw/seq_ctrl_if.sv
// Sequencer to datapath control
`default_nettype none

interface seq_ctrl_if;

    // direction of the transfer in progress
    sdmac_ctrl_pkg::dir_e dir;
    // datapath may handshake bytes
    logic active;
    // next byte handshake is the final one of the transfer
    logic last_byte;
    // a SCSI byte handshake happens this cycle
    logic byte_fire;
    // push the partially packed word now
    logic flush;
    // flushed or final word taken by the rx FIFO
    logic flush_done;

    // sequencer side
    modport seq (
        output dir, active, last_byte, flush,
        input  byte_fire, flush_done
    );

    // datapath side
    modport dp (
        input  dir, active, last_byte, flush,
        output byte_fire, flush_done
    );

endinterface

`default_nettype wire

// File: hw/dma_word_fifo.sv
// DMA word FIFO
`default_nettype none

module dma_word_fifo (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic [sdmac_bus_pkg::word_w-1:0] in_data,
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic [sdmac_bus_pkg::word_w-1:0] out_data
);

    localparam int ptr_w = $clog2(sdmac_bus_pkg::fifo_depth);
    localparam int cnt_w = $clog2(sdmac_bus_pkg::fifo_depth + 1);

    logic [sdmac_bus_pkg::word_w-1:0] mem [sdmac_bus_pkg::fifo_depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic [cnt_w-1:0] count_next;
    logic push;
    logic pop;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // occupancy after this edge
    // push and pop may coincide
    always_comb begin
        count_next = count_q;
        if (push && !pop) begin
            count_next = count_q + cnt_w'(1);
        end else if (pop && !push) begin
            count_next = count_q - cnt_w'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            // not ready until the first edge after reset
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_w'(sdmac_bus_pkg::fifo_depth - 1)) ?
                            '0 : wr_ptr_q + ptr_w'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_w'(sdmac_bus_pkg::fifo_depth - 1)) ?
                            '0 : rd_ptr_q + ptr_w'(1);
            end
            count_q  <= count_next;
            // registered full flag
            in_ready <= (count_next != cnt_w'(sdmac_bus_pkg::fifo_depth));
        end
    end

    // word storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= in_data;
        end
    end

    // head of queue is visible the cycle after its push
    assign out_valid = (count_q != '0);
    assign out_data  = mem[rd_ptr_q];

    // registered ready must track occupancy
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count_q != cnt_w'(sdmac_bus_pkg::fifo_depth)));

    // an underflow or overflow leaves occupancy out of range or off the pointers
    a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
        (count_q <= cnt_w'(sdmac_bus_pkg::fifo_depth)) &&
        (((int'(wr_ptr_q) - int'(rd_ptr_q) + sdmac_bus_pkg::fifo_depth)
          % sdmac_bus_pkg::fifo_depth) == (int'(count_q) % sdmac_bus_pkg::fifo_depth)));

endmodule

`default_nettype wire

// File: hw/datapath_scsi.sv
// SCSI byte lane datapath
`default_nettype none

module datapath_scsi (
    input  logic                             clk,
    input  logic                             rst_n,
    seq_ctrl_if.dp                           ctrl,
    input  logic                             word_in_valid,
    output logic                             word_in_ready,
    input  logic [sdmac_bus_pkg::word_w-1:0] word_in_data,
    output logic                             scsi_tx_valid,
    input  logic                             scsi_tx_ready,
    output logic [sdmac_bus_pkg::byte_w-1:0] scsi_tx_data,
    input  logic                             scsi_rx_valid,
    output logic                             scsi_rx_ready,
    input  logic [sdmac_bus_pkg::byte_w-1:0] scsi_rx_data,
    output logic                             word_out_valid,
    input  logic                             word_out_ready,
    output logic [sdmac_bus_pkg::word_w-1:0] word_out_data
);

    logic tx_active;
    logic rx_active;
    logic tx_fire;
    logic rx_fire;
    logic word_push;
    sdmac_bus_pkg::lane_e tx_lane_q;
    sdmac_bus_pkg::lane_e rx_lane_q;
    // one hot lane select with bit 0 for lane ll
    logic [sdmac_bus_pkg::lanes-1:0] tx_sel;
    logic [sdmac_bus_pkg::lanes-1:0][sdmac_bus_pkg::byte_w-1:0] head_lanes;
    logic [sdmac_bus_pkg::lanes-1:0][sdmac_bus_pkg::byte_w-1:0] pack_q;
    logic [sdmac_bus_pkg::byte_w-1:0] tx_byte;
    // packed word waiting for the rx FIFO
    logic pend_q;
    // partial word holds at least one byte
    logic part_q;

    assign tx_active = ctrl.active && (ctrl.dir == sdmac_ctrl_pkg::dir_to_scsi);
    assign rx_active = ctrl.active && (ctrl.dir == sdmac_ctrl_pkg::dir_from_scsi);

    // transmit lane decoder and byte mux of the FIFO head
    always_comb begin
        tx_sel = '0;
        tx_sel[tx_lane_q] = tx_active;
    end

    assign head_lanes = word_in_data;

    always_comb begin
        tx_byte = '0;
        for (int i = 0; i < sdmac_bus_pkg::lanes; i++) begin
            tx_byte = tx_byte | (head_lanes[i] & {sdmac_bus_pkg::byte_w{tx_sel[i]}});
        end
    end

    assign scsi_tx_valid = tx_active && word_in_valid;
    // bus stays zero outside a to-SCSI transfer
    assign scsi_tx_data  = tx_byte;
    assign tx_fire       = scsi_tx_valid && scsi_tx_ready;
    // pop after lane uu or early on the final byte so trailing lanes drop
    assign word_in_ready = tx_fire && ((tx_lane_q == sdmac_bus_pkg::lane_uu) || ctrl.last_byte);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_lane_q <= sdmac_bus_pkg::lane_ll;
        end else if (word_in_ready) begin
            tx_lane_q <= sdmac_bus_pkg::lane_ll;
        end else if (tx_fire) begin
            tx_lane_q <= sdmac_bus_pkg::lane_e'(tx_lane_q + 2'd1);
        end
    end

    // receive side packs bytes lowest lane first
    assign scsi_rx_ready  = rx_active && !pend_q;
    assign rx_fire        = scsi_rx_valid && scsi_rx_ready;
    assign word_out_valid = pend_q;
    assign word_out_data  = pack_q;
    assign word_push      = word_out_valid && word_out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_lane_q <= sdmac_bus_pkg::lane_ll;
            pend_q    <= 1'b0;
            part_q    <= 1'b0;
        end else begin
            if (word_push) begin
                pend_q <= 1'b0;
            end
            if (rx_fire) begin
                if (rx_lane_q == sdmac_bus_pkg::lane_uu) begin
                    // full word is offered next cycle
                    rx_lane_q <= sdmac_bus_pkg::lane_ll;
                    pend_q    <= 1'b1;
                    part_q    <= 1'b0;
                end else begin
                    rx_lane_q <= sdmac_bus_pkg::lane_e'(rx_lane_q + 2'd1);
                    part_q    <= 1'b1;
                end
            end else if (ctrl.flush && part_q && !pend_q) begin
                // partial word goes out with upper lanes still zero
                rx_lane_q <= sdmac_bus_pkg::lane_ll;
                pend_q    <= 1'b1;
                part_q    <= 1'b0;
            end
        end
    end

    // first byte of a word clears the other lanes of the packing register
    always_ff @(posedge clk) begin
        if (rx_fire) begin
            if (rx_lane_q == sdmac_bus_pkg::lane_ll) begin
                pack_q <= '0;
            end
            pack_q[rx_lane_q] <= scsi_rx_data;
        end
    end

    assign ctrl.byte_fire  = tx_fire || rx_fire;
    // in flush the word taken by the FIFO is the final one
    assign ctrl.flush_done = ctrl.flush && word_push;

    // FIFO head and lane must hold under back-pressure
    a_tx_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (scsi_tx_valid && !scsi_tx_ready) |=> (scsi_tx_valid && $stable(scsi_tx_data)));

    // pending word is not overwritten by a new byte before the rx FIFO takes it
    a_rx_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        (word_out_valid && !word_out_ready) |=> (word_out_valid && $stable(word_out_data)));

endmodule

`default_nettype wire

// File: hw/dma_sequencer.sv
// DMA transfer sequencer
`default_nettype none

module dma_sequencer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  sdmac_ctrl_pkg::dir_e              dir,
    input  logic [sdmac_ctrl_pkg::count_w-1:0] byte_count,
    output logic                              busy,
    output logic                              done,
    seq_ctrl_if.seq                           ctrl
);

    sdmac_ctrl_pkg::seq_state_e state_q;
    sdmac_ctrl_pkg::dir_e dir_q;
    // bytes still to move in this transfer
    logic [sdmac_ctrl_pkg::count_w-1:0] remain_q;
    logic one_left;

    assign one_left = (remain_q == sdmac_ctrl_pkg::count_w'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= sdmac_ctrl_pkg::st_idle;
            dir_q    <= sdmac_ctrl_pkg::dir_to_scsi;
            remain_q <= '0;
        end else begin
            case (state_q)
                sdmac_ctrl_pkg::st_idle: begin
                    // start only sampled here, so a start while busy is dropped
                    if (start) begin
                        dir_q    <= dir;
                        remain_q <= byte_count;
                        if (byte_count == '0) begin
                            state_q <= sdmac_ctrl_pkg::st_done;
                        end else begin
                            state_q <= sdmac_ctrl_pkg::st_move;
                        end
                    end
                end
                sdmac_ctrl_pkg::st_move: begin
                    if (ctrl.byte_fire) begin
                        remain_q <= remain_q - sdmac_ctrl_pkg::count_w'(1);
                        if (one_left) begin
                            // rx side still owes the last packed word
                            if (dir_q == sdmac_ctrl_pkg::dir_from_scsi) begin
                                state_q <= sdmac_ctrl_pkg::st_flush;
                            end else begin
                                state_q <= sdmac_ctrl_pkg::st_done;
                            end
                        end
                    end
                end
                sdmac_ctrl_pkg::st_flush: begin
                    if (ctrl.flush_done) begin
                        state_q <= sdmac_ctrl_pkg::st_done;
                    end
                end
                sdmac_ctrl_pkg::st_done: begin
                    state_q <= sdmac_ctrl_pkg::st_idle;
                end
                default: begin
                    state_q <= sdmac_ctrl_pkg::st_idle;
                end
            endcase
        end
    end

    assign busy = (state_q != sdmac_ctrl_pkg::st_idle);
    // single cycle pulse
    assign done = (state_q == sdmac_ctrl_pkg::st_done);

    // control toward the datapath
    assign ctrl.dir       = dir_q;
    assign ctrl.active    = (state_q == sdmac_ctrl_pkg::st_move);
    assign ctrl.last_byte = ctrl.active && one_left;
    assign ctrl.flush     = (state_q == sdmac_ctrl_pkg::st_flush);

    // datapath moves nothing between transfers
    a_no_fire_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == sdmac_ctrl_pkg::st_idle) |-> !ctrl.byte_fire);

endmodule

`default_nettype wire

// File: hw/sdmac_datapath_top.sv
// SCSI DMA datapath top
`default_nettype none

module sdmac_datapath_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  sdmac_ctrl_pkg::dir_e               dir,
    input  logic [sdmac_ctrl_pkg::count_w-1:0] byte_count,
    output logic                               busy,
    output logic                               done,
    input  logic                               host_in_valid,
    output logic                               host_in_ready,
    input  logic [sdmac_bus_pkg::word_w-1:0]   host_in_data,
    output logic                               host_out_valid,
    input  logic                               host_out_ready,
    output logic [sdmac_bus_pkg::word_w-1:0]   host_out_data,
    output logic                               scsi_tx_valid,
    input  logic                               scsi_tx_ready,
    output logic [sdmac_bus_pkg::byte_w-1:0]   scsi_tx_data,
    input  logic                               scsi_rx_valid,
    output logic                               scsi_rx_ready,
    input  logic [sdmac_bus_pkg::byte_w-1:0]   scsi_rx_data
);

    // tx FIFO head toward the datapath
    logic                             tx_word_valid;
    logic                             tx_word_ready;
    logic [sdmac_bus_pkg::word_w-1:0] tx_word_data;
    // packed words toward the rx FIFO
    logic                             rx_word_valid;
    logic                             rx_word_ready;
    logic [sdmac_bus_pkg::word_w-1:0] rx_word_data;

    seq_ctrl_if u_ctrl_if ();

    // host to SCSI words
    dma_word_fifo u_tx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (host_in_valid),
        .in_ready  (host_in_ready),
        .in_data   (host_in_data),
        .out_valid (tx_word_valid),
        .out_ready (tx_word_ready),
        .out_data  (tx_word_data)
    );

    // SCSI to host words
    dma_word_fifo u_rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (rx_word_valid),
        .in_ready  (rx_word_ready),
        .in_data   (rx_word_data),
        .out_valid (host_out_valid),
        .out_ready (host_out_ready),
        .out_data  (host_out_data)
    );

    datapath_scsi u_datapath_scsi (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl           (u_ctrl_if.dp),
        .word_in_valid  (tx_word_valid),
        .word_in_ready  (tx_word_ready),
        .word_in_data   (tx_word_data),
        .scsi_tx_valid  (scsi_tx_valid),
        .scsi_tx_ready  (scsi_tx_ready),
        .scsi_tx_data   (scsi_tx_data),
        .scsi_rx_valid  (scsi_rx_valid),
        .scsi_rx_ready  (scsi_rx_ready),
        .scsi_rx_data   (scsi_rx_data),
        .word_out_valid (rx_word_valid),
        .word_out_ready (rx_word_ready),
        .word_out_data  (rx_word_data)
    );

    dma_sequencer u_dma_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .dir        (dir),
        .byte_count (byte_count),
        .busy       (busy),
        .done       (done),
        .ctrl       (u_ctrl_if.seq)
    );

endmodule

`default_nettype wire

// File: tb/tb_sdmac_model.svh
// DMA datapath reference model
`ifndef TB_SDMAC_MODEL_SVH
`define TB_SDMAC_MODEL_SVH

// host words still to be pushed for a to-SCSI transfer
logic [sdmac_bus_pkg::word_w-1:0] feed_words[$];
// bytes expected on scsi_tx, in bus order
logic [sdmac_bus_pkg::byte_w-1:0] exp_bytes[$];
// bytes the SCSI side still has to send
logic [sdmac_bus_pkg::byte_w-1:0] src_bytes[$];
// packed words expected on host_out
logic [sdmac_bus_pkg::word_w-1:0] exp_words[$];

task automatic clear_model();
    feed_words.delete();
    exp_bytes.delete();
    src_bytes.delete();
    exp_words.delete();
endtask

// each host word goes out lane ll first, lanes past the count are dropped
task automatic build_to_scsi(input int count);
    logic [sdmac_bus_pkg::word_w-1:0] w;
    sdmac_bus_pkg::lane_e ln;
    int sent;
    sent = 0;
    while (sent < count) begin
        w = next_random();
        feed_words.push_back(w);
        for (int i = 0; i < sdmac_bus_pkg::lanes; i++) begin
            ln = sdmac_bus_pkg::lane_e'(2'(i));
            if (sent < count) begin
                exp_bytes.push_back(w[int'(ln) * sdmac_bus_pkg::byte_w +: sdmac_bus_pkg::byte_w]);
                sent++;
            end
        end
    end
endtask

// received bytes packed lowest lane first
task automatic build_from_scsi(input int count);
    logic [sdmac_bus_pkg::word_w-1:0] w;
    logic [31:0] r;
    logic [sdmac_bus_pkg::byte_w-1:0] b;
    sdmac_bus_pkg::lane_e ln;
    w = '0;
    for (int i = 0; i < count; i++) begin
        r = next_random();
        b = r[sdmac_bus_pkg::byte_w-1:0];
        ln = sdmac_bus_pkg::lane_e'(2'(i % sdmac_bus_pkg::lanes));
        src_bytes.push_back(b);
        w[int'(ln) * sdmac_bus_pkg::byte_w +: sdmac_bus_pkg::byte_w] = b;
        // full word, or the short last one with zero upper lanes
        if (ln == sdmac_bus_pkg::lane_uu || i == count - 1) begin
            exp_words.push_back(w);
            w = '0;
        end
    end
endtask

`endif

// File: tb/tb_sdmac_datapath.sv
// SCSI DMA datapath testbench
`default_nettype none

module tb_sdmac_datapath;

    // per transfer cycle limit with room for heavy back-pressure
    localparam int max_cycles = 2000;
    localparam int n_random = 40;

    logic clk;
    logic rst_n;
    logic start;
    sdmac_ctrl_pkg::dir_e dir;
    logic [sdmac_ctrl_pkg::count_w-1:0] byte_count;
    logic busy;
    logic done;
    logic host_in_valid;
    logic host_in_ready;
    logic [sdmac_bus_pkg::word_w-1:0] host_in_data;
    logic host_out_valid;
    logic host_out_ready;
    logic [sdmac_bus_pkg::word_w-1:0] host_out_data;
    logic scsi_tx_valid;
    logic scsi_tx_ready;
    logic [sdmac_bus_pkg::byte_w-1:0] scsi_tx_data;
    logic scsi_rx_valid;
    logic scsi_rx_ready;
    logic [sdmac_bus_pkg::byte_w-1:0] scsi_rx_data;
    logic [31:0] rng_state;

    sdmac_datapath_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .dir            (dir),
        .byte_count     (byte_count),
        .busy           (busy),
        .done           (done),
        .host_in_valid  (host_in_valid),
        .host_in_ready  (host_in_ready),
        .host_in_data   (host_in_data),
        .host_out_valid (host_out_valid),
        .host_out_ready (host_out_ready),
        .host_out_data  (host_out_data),
        .scsi_tx_valid  (scsi_tx_valid),
        .scsi_tx_ready  (scsi_tx_ready),
        .scsi_tx_data   (scsi_tx_data),
        .scsi_rx_valid  (scsi_rx_valid),
        .scsi_rx_ready  (scsi_rx_ready),
        .scsi_rx_data   (scsi_rx_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // xorshift32 step
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    `include "tb_sdmac_model.svh"

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED at %0t: %s expected %0b got %0b",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input logic [sdmac_bus_pkg::byte_w-1:0] act,
                              input logic [sdmac_bus_pkg::byte_w-1:0] exp);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED at %0t: %s expected %02h got %02h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [sdmac_bus_pkg::word_w-1:0] act,
                              input logic [sdmac_bus_pkg::word_w-1:0] exp);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED at %0t: %s expected %08h got %08h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_dir(input string name, input sdmac_ctrl_pkg::dir_e act,
                             input sdmac_ctrl_pkg::dir_e exp);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED at %0t: %s expected %s got %s",
                               $time, name, exp.name(), act.name()));
        end
    endtask

    // one transfer with every stream stepped on the falling edge
    // DUT outputs seen here are the ones the next rising edge samples
    task automatic run_transfer(input sdmac_ctrl_pkg::dir_e tdir, input int count);
        int cycles;
        int dones;
        int ghost_at;
        logic feed_pend;
        logic src_pend;
        logic [31:0] r;
        clear_model();
        if (tdir == sdmac_ctrl_pkg::dir_to_scsi) begin
            build_to_scsi(count);
        end else begin
            build_from_scsi(count);
        end
        cycles = 0;
        dones = 0;
        feed_pend = 1'b0;
        src_pend = 1'b0;
        ghost_at = 1 + int'(next_random() % 32'd6);
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        // previous transfer left no word or byte behind
        check_bit("host_out_valid", host_out_valid, 1'b0);
        check_bit("scsi_tx_valid", scsi_tx_valid, 1'b0);
        start = 1'b1;
        dir = tdir;
        byte_count = sdmac_ctrl_pkg::count_w'(count);
        host_in_valid = 1'b0;
        scsi_rx_valid = 1'b0;
        while (dones == 0 || exp_words.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > max_cycles) begin
                stop_run("transfer did not finish within the cycle limit");
            end
            r = next_random();
            // busy from the cycle after start until the done pulse
            check_bit("busy", busy, (dones == 0));
            if (count == 0 && cycles == 1) begin
                check_bit("done", done, 1'b1);
            end
            if (done) begin
                dones++;
                if (dones > 1) begin
                    stop_run("done pulsed more than once in one transfer");
                end
                if (feed_words.size() != 0 || exp_bytes.size() != 0 || src_bytes.size() != 0) begin
                    stop_run("done came before all bytes of the transfer moved");
                end
            end
            // second request while busy is dropped by the sequencer
            start = busy && (cycles == ghost_at);
            if (start) begin
                dir = sdmac_ctrl_pkg::dir_e'(~tdir);
                byte_count = sdmac_ctrl_pkg::count_w'(r[17:13]);
            end
            // host feed holds each word until accepted
            if (!feed_pend) begin
                feed_pend = (feed_words.size() != 0) && (r[2:1] != 2'b00);
                host_in_valid = feed_pend;
                if (feed_pend) begin
                    host_in_data = feed_words[0];
                end
            end
            if (feed_pend && host_in_ready) begin
                void'(feed_words.pop_front());
                feed_pend = 1'b0;
            end
            // SCSI byte sink with random stalls
            scsi_tx_ready = (r[4:3] != 2'b00);
            if (scsi_tx_valid) begin
                check_dir("scsi_tx_valid direction", sdmac_ctrl_pkg::dir_to_scsi, tdir);
                if (exp_bytes.size() == 0) begin
                    stop_run("scsi_tx_valid high with no byte left to send");
                end else begin
                    check_byte("scsi_tx_data", scsi_tx_data, exp_bytes[0]);
                    if (scsi_tx_ready) begin
                        void'(exp_bytes.pop_front());
                    end
                end
            end
            // SCSI byte source holds each byte until accepted
            if (scsi_rx_ready) begin
                check_dir("scsi_rx_ready direction", sdmac_ctrl_pkg::dir_from_scsi, tdir);
            end
            if (!src_pend) begin
                src_pend = (src_bytes.size() != 0) && (r[7:6] != 2'b00);
                scsi_rx_valid = src_pend;
                if (src_pend) begin
                    scsi_rx_data = src_bytes[0];
                end
            end
            if (src_pend && scsi_rx_ready) begin
                void'(src_bytes.pop_front());
                src_pend = 1'b0;
            end
            // host drain mostly stalled so the rx FIFO fills up
            host_out_ready = (r[9:8] == 2'b00);
            if (host_out_valid) begin
                if (exp_words.size() == 0) begin
                    stop_run("host_out_valid high with no word expected");
                end else begin
                    check_word("host_out_data", host_out_data, exp_words[0]);
                    if (host_out_ready) begin
                        void'(exp_words.pop_front());
                    end
                end
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        rng_state = 32'd86795;
        rst_n = 1'b0;
        start = 1'b0;
        dir = sdmac_ctrl_pkg::dir_to_scsi;
        byte_count = '0;
        host_in_valid = 1'b0;
        host_in_data = '0;
        host_out_ready = 1'b0;
        scsi_tx_ready = 1'b0;
        scsi_rx_valid = 1'b0;
        scsi_rx_data = '0;
        repeat (10) @(negedge clk);
        // everything quiet while reset holds
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("scsi_tx_valid", scsi_tx_valid, 1'b0);
        check_bit("host_out_valid", host_out_valid, 1'b0);
        check_bit("scsi_rx_ready", scsi_rx_ready, 1'b0);
        check_bit("host_in_ready", host_in_ready, 1'b0);
        rst_n = 1'b1;
        @(negedge clk);
        // empty tx FIFO opens one cycle after reset
        check_bit("host_in_ready", host_in_ready, 1'b1);
        check_bit("busy", busy, 1'b0);
        check_bit("scsi_tx_valid", scsi_tx_valid, 1'b0);
        check_bit("scsi_rx_ready", scsi_rx_ready, 1'b0);
        // whole words, short tails, then zero length
        run_transfer(sdmac_ctrl_pkg::dir_to_scsi, 8);
        run_transfer(sdmac_ctrl_pkg::dir_to_scsi, 7);
        run_transfer(sdmac_ctrl_pkg::dir_to_scsi, 4);
        run_transfer(sdmac_ctrl_pkg::dir_from_scsi, 8);
        run_transfer(sdmac_ctrl_pkg::dir_from_scsi, 5);
        run_transfer(sdmac_ctrl_pkg::dir_to_scsi, 0);
        run_transfer(sdmac_ctrl_pkg::dir_from_scsi, 0);
        for (int n = 0; n < n_random; n++) begin
            r = next_random();
            run_transfer(sdmac_ctrl_pkg::dir_e'(r[0]), 1 + int'(r[15:8] % 8'd23));
        end
        // no extra word after the last transfer
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
        check_bit("host_out_valid", host_out_valid, 1'b0);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: sdmac_datapath_top.f
+incdir+tb
hw/sdmac_bus_pkg.sv
hw/sdmac_ctrl_pkg.sv
hw/seq_ctrl_if.sv
hw/dma_word_fifo.sv
hw/datapath_scsi.sv
hw/dma_sequencer.sv
hw/sdmac_datapath_top.sv
tb/tb_sdmac_datapath.sv

// File: run_sim.sh
#!/bin/sh
# build the DMA datapath testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sdmac_datapath_top.f \
    --top-module tb_sdmac_datapath --Mdir obj_dir -o tb_sdmac_datapath &&
./obj_dir/tb_sdmac_datapath || exit 1
